// ==== include/decoder_settings.svh ====
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// Flow control

// Bundles allowed in flight downstream
// Consumer must buffer this many without stalling
`define DEC_CREDITS 2

// Core configuration

// Multiply/divide support by default
// Set to 0 to trap every RV32M encoding
`define DEC_RV32M 1

// Fetched instruction word width
`define DEC_ILEN 32

`endif

// ==== verilog/decoder_pkg.sv ====
package decoder_pkg;

  // Major opcodes of the kept groups
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_FENCE  = 7'b0001111,
    OPCODE_OPIMM  = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_JAL    = 7'b1101111,
    OPCODE_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operators, compares last
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLTS, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;

  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;
  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  // Access size, word is zero
  typedef enum logic [1:0] {DT_WORD, DT_HALF, DT_BYTE} data_type_e;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       imm_a_zero;  // Zero immediate on operand A
    logic       reg_we;
    logic       jump;
    logic       branch;
  } alu_ctrl_t;

  typedef struct packed {
    logic       req;
    logic       we;
    data_type_e data_type;
    logic       sign_ext;    // Loads only
  } lsu_ctrl_t;

  typedef struct packed {
    logic       mult_en;
    logic       div_en;
    md_op_e     md_op;
    logic [1:0] signed_mode; // Bit 0 for A, bit 1 for B
  } md_ctrl_t;

  typedef struct packed {
    logic    csr_access;
    csr_op_e csr_op;
    logic    csr_status;     // mstatus touched
    logic    ecall;
    logic    ebreak;
    logic    mret;
    logic    flush;
    logic    reg_we;
  } sys_ctrl_t;

  typedef struct packed {
    alu_ctrl_t alu;
    lsu_ctrl_t lsu;
    md_ctrl_t  md;
    sys_ctrl_t sys;
    logic      illegal;
  } dec_bundle_t;

  // Per group verdict
  typedef struct packed {
    logic hit;               // Opcode owned by this group
    logic illegal;           // Bad encoding inside the group
  } grp_result_t;

endpackage

// ==== verilog/alu_decoder.sv ====
`include "decoder_settings.svh"

module alu_decoder (
  input  logic [`DEC_ILEN-1:0]    instr_i,
  output decoder_pkg::alu_ctrl_t   alu_o,
  output decoder_pkg::grp_result_t res_o
);
  import decoder_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    alu_o = '0;  // Add on register operands
    res_o = '0;
    case (opcode)
      ////////////////////
      // Upper immediates
      ////////////////////
      OPCODE_LUI: begin
        res_o.hit        = 1'b1;
        alu_o.op_a_sel   = OP_A_IMM;
        alu_o.op_b_sel   = OP_B_IMM;
        alu_o.imm_a_zero = 1'b1;      // 0 + imm
        alu_o.imm_b_sel  = IMMB_U;
        alu_o.reg_we     = 1'b1;
      end
      OPCODE_AUIPC: begin
        res_o.hit       = 1'b1;
        alu_o.op_a_sel  = OP_A_CURRPC;
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_U;
        alu_o.reg_we    = 1'b1;
      end
      ////////////////////
      // Jumps, branches
      ////////////////////
      OPCODE_JAL, OPCODE_JALR: begin
        res_o.hit       = 1'b1;
        alu_o.op_a_sel  = OP_A_CURRPC;  // Link value PC+4
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_PCINCR;
        alu_o.reg_we    = 1'b1;
        alu_o.jump      = 1'b1;
        // JALR has funct3 fixed at zero
        if (opcode == OPCODE_JALR && funct3 != 3'b000) res_o.illegal = 1'b1;
      end
      OPCODE_BRANCH: begin
        res_o.hit    = 1'b1;
        alu_o.branch = 1'b1;            // Compare only, target computed later
        case (funct3)
          3'b000:  alu_o.alu_op = ALU_EQ;
          3'b001:  alu_o.alu_op = ALU_NE;
          3'b100:  alu_o.alu_op = ALU_LTS;
          3'b101:  alu_o.alu_op = ALU_GES;
          3'b110:  alu_o.alu_op = ALU_LTU;
          3'b111:  alu_o.alu_op = ALU_GEU;
          default: res_o.illegal = 1'b1;  // 010, 011 reserved
        endcase
      end
      ////////////////////
      // Integer ALU
      ////////////////////
      OPCODE_OPIMM: begin
        res_o.hit       = 1'b1;
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_I;
        alu_o.reg_we    = 1'b1;
        case (funct3)
          3'b000: alu_o.alu_op = ALU_ADD;
          3'b010: alu_o.alu_op = ALU_SLTS;
          3'b011: alu_o.alu_op = ALU_SLTU;
          3'b100: alu_o.alu_op = ALU_XOR;
          3'b110: alu_o.alu_op = ALU_OR;
          3'b111: alu_o.alu_op = ALU_AND;
          3'b001: begin
            alu_o.alu_op  = ALU_SLL;
            res_o.illegal = (funct7 != 7'h00);  // Shamt only
          end
          default: begin                        // 101
            alu_o.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
            res_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPCODE_OP: begin
        // funct7 of 1 is RV32M, owned elsewhere
        res_o.hit    = (funct7 != 7'h01);
        alu_o.reg_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: alu_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: alu_o.alu_op = ALU_SLTS;
          {7'h00, 3'b011}: alu_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: alu_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: alu_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: alu_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: alu_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: alu_o.alu_op = ALU_AND;
          default:         res_o.illegal = 1'b1;  // Unknown pair
        endcase
      end
      default: ;  // Not an ALU group opcode
    endcase
  end

endmodule

// ==== verilog/lsu_decoder.sv ====
`include "decoder_settings.svh"

module lsu_decoder (
  input  logic [`DEC_ILEN-1:0]    instr_i,
  output decoder_pkg::lsu_ctrl_t   lsu_o,
  output decoder_pkg::grp_result_t res_o
);
  import decoder_pkg::*;

  logic [2:0] funct3;
  data_type_e size;

  assign funct3 = instr_i[14:12];

  // Size field shared by loads and stores
  always_comb begin
    case (funct3[1:0])
      2'b00:   size = DT_BYTE;
      2'b01:   size = DT_HALF;
      default: size = DT_WORD;  // 11 flagged below
    endcase
  end

  always_comb begin
    lsu_o = '0;
    res_o = '0;
    case (instr_i[6:0])
      OPCODE_LOAD: begin
        res_o.hit       = 1'b1;
        lsu_o.req       = 1'b1;
        lsu_o.data_type = size;
        lsu_o.sign_ext  = ~funct3[2];  // LBU, LHU zero extend
        // LD and the two unused slots
        res_o.illegal   = (funct3 == 3'b011) || (funct3 == 3'b110) ||
                          (funct3 == 3'b111);
      end
      OPCODE_STORE: begin
        res_o.hit       = 1'b1;
        lsu_o.req       = 1'b1;
        lsu_o.we        = 1'b1;
        lsu_o.data_type = size;
        // SD and register offset forms
        res_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/muldiv_decoder.sv ====
`include "decoder_settings.svh"

module muldiv_decoder #(
  parameter int unsigned RV32M = `DEC_RV32M
) (
  input  logic [`DEC_ILEN-1:0]    instr_i,
  output decoder_pkg::md_ctrl_t    md_o,
  output decoder_pkg::grp_result_t res_o
);
  import decoder_pkg::*;

  logic md_insn;  // OP with funct7 of 1
  logic en;

  assign md_insn = (instr_i[6:0] == OPCODE_OP) && (instr_i[31:25] == 7'h01);
  assign en      = md_insn && (RV32M != 0);

  always_comb begin
    md_o          = '0;
    res_o.hit     = md_insn;
    res_o.illegal = md_insn && (RV32M == 0);  // Trap when unit absent
    if (md_insn) begin
      case (instr_i[14:12])
        3'b000: md_o.md_op = MD_OP_MULL;        // mul
        3'b001: begin                           // mulh
          md_o.md_op       = MD_OP_MULH;
          md_o.signed_mode = 2'b11;
        end
        3'b010: begin                           // mulhsu
          md_o.md_op       = MD_OP_MULH;
          md_o.signed_mode = 2'b01;
        end
        3'b011: md_o.md_op = MD_OP_MULH;        // mulhu
        3'b100: begin                           // div
          md_o.md_op       = MD_OP_DIV;
          md_o.signed_mode = 2'b11;
        end
        3'b101: md_o.md_op = MD_OP_DIV;         // divu
        3'b110: begin                           // rem
          md_o.md_op       = MD_OP_REM;
          md_o.signed_mode = 2'b11;
        end
        default: md_o.md_op = MD_OP_REM;        // remu
      endcase
    end
    // Multiplies have funct3 bit 2 clear
    md_o.mult_en = en && !instr_i[14];
    md_o.div_en  = en && instr_i[14];
  end

endmodule

// ==== verilog/system_decoder.sv ====
`include "decoder_settings.svh"

module system_decoder (
  input  logic [`DEC_ILEN-1:0]    instr_i,
  output decoder_pkg::sys_ctrl_t   sys_o,
  output decoder_pkg::grp_result_t res_o
);
  import decoder_pkg::*;

  logic [2:0]  funct3;
  logic [11:0] imm12;  // Also the CSR address

  assign funct3 = instr_i[14:12];
  assign imm12  = instr_i[31:20];

  always_comb begin
    sys_o = '0;
    res_o = '0;
    case (instr_i[6:0])
      ////////////////////
      // SYSTEM
      ////////////////////
      OPCODE_SYSTEM: begin
        res_o.hit = 1'b1;
        if (funct3 == 3'b000) begin
          // Privileged, no CSR access
          case (imm12)
            12'h000: sys_o.ecall  = 1'b1;
            12'h001: sys_o.ebreak = 1'b1;
            12'h302: sys_o.mret   = 1'b1;
            12'h105: sys_o.flush  = 1'b1;  // WFI drains the pipe
            default: res_o.illegal = 1'b1;
          endcase
        end else if (funct3 == 3'b100) begin
          res_o.illegal = 1'b1;            // No such CSR form
        end else begin
          sys_o.csr_access = 1'b1;
          sys_o.reg_we     = 1'b1;         // Old value to rd
          case (funct3[1:0])
            2'b01:   sys_o.csr_op = CSR_OP_WRITE;
            2'b10:   sys_o.csr_op = CSR_OP_SET;
            default: sys_o.csr_op = CSR_OP_CLEAR;
          endcase
          sys_o.csr_status = (imm12 == 12'h300);  // mstatus
        end
      end
      ////////////////////
      // FENCE
      ////////////////////
      OPCODE_FENCE: begin
        res_o.hit = 1'b1;
        case (funct3)
          3'b000:  ;                        // Ordering is trivial here
          3'b001:  sys_o.flush = 1'b1;      // FENCE.I refetches
          default: res_o.illegal = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/decode_ctrl.sv ====
`include "decoder_settings.svh"

module decode_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     instr_valid_i,
  output logic                     instr_ready_o,
  input  logic                     credit_return_i,
  input  decoder_pkg::alu_ctrl_t   alu_i,
  input  decoder_pkg::lsu_ctrl_t   lsu_i,
  input  decoder_pkg::md_ctrl_t    md_i,
  input  decoder_pkg::sys_ctrl_t   sys_i,
  input  decoder_pkg::grp_result_t alu_res_i,
  input  decoder_pkg::grp_result_t lsu_res_i,
  input  decoder_pkg::grp_result_t md_res_i,
  input  decoder_pkg::grp_result_t sys_res_i,
  output decoder_pkg::dec_bundle_t bundle_o,
  output logic                     bundle_valid_o
);
  import decoder_pkg::*;

  localparam int CW = $clog2(`DEC_CREDITS + 1);
  localparam logic [CW-1:0] MAX_CREDITS = CW'(`DEC_CREDITS);

  logic [CW-1:0] credit_q;
  logic [CW-1:0] credit_d;
  logic          accept;
  logic [3:0]    hit;
  logic [3:0]    bad;
  logic          illegal;
  dec_bundle_t   bundle_d;

  ////////////////////
  // Credits
  ////////////////////
  assign instr_ready_o = (credit_q != '0);
  assign accept        = instr_valid_i && instr_ready_o;

  always_comb begin
    credit_d = credit_q;  // Take and return cancel out
    if (accept && !credit_return_i) begin
      credit_d = credit_q - 1'b1;
    end else if (!accept && credit_return_i && credit_q != MAX_CREDITS) begin
      credit_d = credit_q + 1'b1;
    end
  end

  ////////////////////
  // Illegal merge
  ////////////////////
  assign hit     = {alu_res_i.hit, lsu_res_i.hit, md_res_i.hit, sys_res_i.hit};
  assign bad     = {alu_res_i.illegal, lsu_res_i.illegal, md_res_i.illegal,
                    sys_res_i.illegal};
  assign illegal = (hit == '0) || ((hit & bad) != '0);  // Unknown opcode or bad field

  always_comb begin
    bundle_d = '{alu: alu_i, lsu: lsu_i, md: md_i, sys: sys_i, illegal: illegal};
    if (illegal) begin
      // Nothing may take effect downstream
      bundle_d.alu.reg_we  = 1'b0;
      bundle_d.alu.jump    = 1'b0;
      bundle_d.alu.branch  = 1'b0;
      bundle_d.lsu.req     = 1'b0;
      bundle_d.lsu.we      = 1'b0;
      bundle_d.md.mult_en  = 1'b0;
      bundle_d.md.div_en   = 1'b0;
      bundle_d.sys.csr_op  = CSR_OP_NONE;
      bundle_d.sys.reg_we  = 1'b0;
    end
  end

  ////////////////////
  // Output stage
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q       <= MAX_CREDITS;  // Consumer starts empty
      bundle_valid_o <= 1'b0;
      bundle_o       <= '0;
    end else begin
      credit_q       <= credit_d;
      bundle_valid_o <= accept;       // Single cycle pulse per bundle
      if (accept) bundle_o <= bundle_d;
    end
  end

endmodule

// ==== verilog/decoder_top.sv ====
`include "decoder_settings.svh"

module decoder_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`DEC_ILEN-1:0]     instr_i,
  input  logic                     instr_valid_i,
  output logic                     instr_ready_o,
  input  logic                     credit_return_i,
  output decoder_pkg::dec_bundle_t bundle_o,
  output logic                     bundle_valid_o
);
  import decoder_pkg::*;

  // Group decoder outputs
  alu_ctrl_t   alu;
  lsu_ctrl_t   lsu;
  md_ctrl_t    md;
  sys_ctrl_t   sys;
  grp_result_t alu_res;
  grp_result_t lsu_res;
  grp_result_t md_res;
  grp_result_t sys_res;

  // All four look at the same word in parallel
  alu_decoder u_alu_dec (.instr_i(instr_i), .alu_o(alu), .res_o(alu_res));
  lsu_decoder u_lsu_dec (.instr_i(instr_i), .lsu_o(lsu), .res_o(lsu_res));
  muldiv_decoder #(.RV32M(`DEC_RV32M)) u_md_dec (
    .instr_i (instr_i),
    .md_o    (md),
    .res_o   (md_res)
  );
  system_decoder u_sys_dec (.instr_i(instr_i), .sys_o(sys), .res_o(sys_res));

  // Merge, credit gate and output register
  decode_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_ready_o   (instr_ready_o),
    .credit_return_i (credit_return_i),
    .alu_i           (alu),
    .lsu_i           (lsu),
    .md_i            (md),
    .sys_i           (sys),
    .alu_res_i       (alu_res),
    .lsu_res_i       (lsu_res),
    .md_res_i        (md_res),
    .sys_res_i       (sys_res),
    .bundle_o        (bundle_o),
    .bundle_valid_o  (bundle_valid_o)
  );

endmodule

// ==== verif/decoder_vectors.svh ====
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

localparam int NUM_VECS = 26;

task automatic load_vectors();
  ////////////////////
  // ALU group
  ////////////////////
  instr_tab[0]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP);     // add
  exp_tab[0]    = mk_bundle(mk_alu(ALU_ADD, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, '0, '0, 1'b0);
  instr_tab[1]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP);     // sub
  exp_tab[1]    = mk_bundle(mk_alu(ALU_SUB, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, '0, '0, 1'b0);
  instr_tab[2]  = enc_r(7'h20, 5'd4, 5'd5, 3'b101, 5'd6, OPCODE_OP);     // sra
  exp_tab[2]    = mk_bundle(mk_alu(ALU_SRA, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, '0, '0, 1'b0);
  instr_tab[3]  = enc_i(12'h07f, 5'd1, 3'b011, 5'd2, OPCODE_OPIMM);      // sltiu
  exp_tab[3]    = mk_bundle(mk_alu(ALU_SLTU, OP_A_REG, OP_B_IMM, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, '0, '0, 1'b0);
  instr_tab[4]  = enc_i(12'h004, 5'd1, 3'b001, 5'd2, OPCODE_OPIMM);      // slli
  exp_tab[4]    = mk_bundle(mk_alu(ALU_SLL, OP_A_REG, OP_B_IMM, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, '0, '0, 1'b0);
  instr_tab[5]  = enc_i(12'h404, 5'd1, 3'b001, 5'd2, OPCODE_OPIMM);      // Bad shift funct7
  exp_tab[5]    = mk_bundle(mk_alu(ALU_SLL, OP_A_REG, OP_B_IMM, IMMB_I, 1'b0, 1'b0, 1'b0, 1'b0),
                            '0, '0, '0, 1'b1);
  ////////////////////
  // Control flow
  ////////////////////
  instr_tab[6]  = enc_u(20'h00100, 5'd1, OPCODE_JAL);
  exp_tab[6]    = mk_bundle(mk_alu(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b0, 1'b1,
                                   1'b1, 1'b0), '0, '0, '0, 1'b0);
  instr_tab[7]  = enc_i(12'h010, 5'd2, 3'b000, 5'd1, OPCODE_JALR);
  exp_tab[7]    = mk_bundle(mk_alu(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b0, 1'b1,
                                   1'b1, 1'b0), '0, '0, '0, 1'b0);
  instr_tab[8]  = enc_s(12'h008, 5'd2, 5'd1, 3'b000, OPCODE_BRANCH);     // beq
  exp_tab[8]    = mk_bundle(mk_alu(ALU_EQ, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b0, 1'b0, 1'b1),
                            '0, '0, '0, 1'b0);
  instr_tab[9]  = enc_s(12'h008, 5'd2, 5'd1, 3'b111, OPCODE_BRANCH);     // bgeu
  exp_tab[9]    = mk_bundle(mk_alu(ALU_GEU, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b0, 1'b0, 1'b1),
                            '0, '0, '0, 1'b0);
  instr_tab[10] = enc_s(12'h008, 5'd2, 5'd1, 3'b010, OPCODE_BRANCH);     // Reserved funct3
  exp_tab[10]   = mk_bundle('0, '0, '0, '0, 1'b1);
  ////////////////////
  // Memory
  ////////////////////
  instr_tab[11] = enc_i(12'h004, 5'd1, 3'b000, 5'd2, OPCODE_LOAD);       // lb
  exp_tab[11]   = mk_bundle('0, mk_lsu(1'b1, 1'b0, DT_BYTE, 1'b1), '0, '0, 1'b0);
  instr_tab[12] = enc_i(12'h004, 5'd1, 3'b101, 5'd2, OPCODE_LOAD);       // lhu
  exp_tab[12]   = mk_bundle('0, mk_lsu(1'b1, 1'b0, DT_HALF, 1'b0), '0, '0, 1'b0);
  instr_tab[13] = enc_i(12'h008, 5'd1, 3'b010, 5'd2, OPCODE_LOAD);       // lw
  exp_tab[13]   = mk_bundle('0, mk_lsu(1'b1, 1'b0, DT_WORD, 1'b1), '0, '0, 1'b0);
  instr_tab[14] = enc_s(12'h00c, 5'd3, 5'd1, 3'b000, OPCODE_STORE);      // sb
  exp_tab[14]   = mk_bundle('0, mk_lsu(1'b1, 1'b1, DT_BYTE, 1'b0), '0, '0, 1'b0);
  instr_tab[15] = enc_s(12'h00c, 5'd3, 5'd1, 3'b010, OPCODE_STORE);      // sw
  exp_tab[15]   = mk_bundle('0, mk_lsu(1'b1, 1'b1, DT_WORD, 1'b0), '0, '0, 1'b0);
  instr_tab[16] = enc_s(12'h00c, 5'd3, 5'd1, 3'b011, OPCODE_STORE);      // Size 3
  exp_tab[16]   = mk_bundle('0, mk_lsu(1'b0, 1'b0, DT_WORD, 1'b0), '0, '0, 1'b1);
  ////////////////////
  // RV32M, rd still written
  ////////////////////
  instr_tab[17] = enc_r(7'h01, 5'd2, 5'd1, 3'b010, 5'd3, OPCODE_OP);     // mulhsu
  exp_tab[17]   = mk_bundle(mk_alu(ALU_ADD, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, mk_md(1'b1, 1'b0, MD_OP_MULH, 2'b01), '0, 1'b0);
  instr_tab[18] = enc_r(7'h01, 5'd2, 5'd1, 3'b101, 5'd3, OPCODE_OP);     // divu
  exp_tab[18]   = mk_bundle(mk_alu(ALU_ADD, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, mk_md(1'b0, 1'b1, MD_OP_DIV, 2'b00), '0, 1'b0);
  instr_tab[19] = enc_r(7'h01, 5'd2, 5'd1, 3'b110, 5'd3, OPCODE_OP);     // rem
  exp_tab[19]   = mk_bundle(mk_alu(ALU_ADD, OP_A_REG, OP_B_REG, IMMB_I, 1'b0, 1'b1, 1'b0, 1'b0),
                            '0, mk_md(1'b0, 1'b1, MD_OP_REM, 2'b11), '0, 1'b0);
  ////////////////////
  // System
  ////////////////////
  instr_tab[20] = enc_i(12'h300, 5'd1, 3'b010, 5'd5, OPCODE_SYSTEM);     // csrrs mstatus
  exp_tab[20]   = mk_bundle('0, '0, '0, mk_sys(1'b1, CSR_OP_SET, 1'b1, 4'b0000, 1'b1), 1'b0);
  instr_tab[21] = enc_i(12'h000, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM);     // ecall
  exp_tab[21]   = mk_bundle('0, '0, '0, mk_sys(1'b0, CSR_OP_NONE, 1'b0, 4'b1000, 1'b0), 1'b0);
  instr_tab[22] = enc_i(12'h302, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM);     // mret
  exp_tab[22]   = mk_bundle('0, '0, '0, mk_sys(1'b0, CSR_OP_NONE, 1'b0, 4'b0010, 1'b0), 1'b0);
  instr_tab[23] = enc_i(12'h000, 5'd0, 3'b001, 5'd0, OPCODE_FENCE);      // fence.i
  exp_tab[23]   = mk_bundle('0, '0, '0, mk_sys(1'b0, CSR_OP_NONE, 1'b0, 4'b0001, 1'b0), 1'b0);
  instr_tab[24] = enc_i(12'h105, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM);     // wfi
  exp_tab[24]   = mk_bundle('0, '0, '0, mk_sys(1'b0, CSR_OP_NONE, 1'b0, 4'b0001, 1'b0), 1'b0);
  instr_tab[25] = 32'h0000007f;                                          // No such opcode
  exp_tab[25]   = mk_bundle('0, '0, '0, '0, 1'b1);
endtask

`endif

// ==== verif/decoder_tb.sv ====
`include "decoder_settings.svh"

module decoder_tb;
  import decoder_pkg::*;

  localparam int WAIT_LIMIT = 200;  // Cycles per wait loop

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic        credit_return_i;
  dec_bundle_t bundle_o;
  logic        bundle_valid_o;

  logic [31:0] instr_tab [0:31];
  dec_bundle_t exp_tab   [0:31];
  int          delay_tab [0:31];  // Credit return delay per row

  int mismatches = 0;
  int other_errs = 0;
  int cycle      = 0;
  int received   = 0;
  int outstanding = 0;  // Credits held downstream
  bit saw_stall  = 1'b0;
  bit timed_out  = 1'b0;
  int idx_q[$];
  int acc_cycle_q[$];
  int due_q[$];         // Cycles when a credit goes back

  decoder_top dut_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .instr_ready_o   (instr_ready_o),
    .credit_return_i (credit_return_i),
    .bundle_o        (bundle_o),
    .bundle_valid_o  (bundle_valid_o)
  );

  ////////////////////
  // Encoders and bundle builders
  ////////////////////
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic alu_ctrl_t mk_alu(alu_op_e op, op_a_sel_e a, op_b_sel_e b,
                                       imm_b_sel_e imm, logic immz, logic we,
                                       logic jump, logic branch);
    alu_ctrl_t c;
    c = '{alu_op: op, op_a_sel: a, op_b_sel: b, imm_b_sel: imm, imm_a_zero: immz,
          reg_we: we, jump: jump, branch: branch};
    return c;
  endfunction

  function automatic lsu_ctrl_t mk_lsu(logic req, logic we, data_type_e dt, logic sext);
    lsu_ctrl_t c;
    c = '{req: req, we: we, data_type: dt, sign_ext: sext};
    return c;
  endfunction

  function automatic md_ctrl_t mk_md(logic mul, logic div, md_op_e op, logic [1:0] mode);
    md_ctrl_t c;
    c = '{mult_en: mul, div_en: div, md_op: op, signed_mode: mode};
    return c;
  endfunction

  // Flags are ecall, ebreak, mret, flush
  function automatic sys_ctrl_t mk_sys(logic acc, csr_op_e op, logic status,
                                       logic [3:0] flags, logic we);
    sys_ctrl_t c;
    c = '{csr_access: acc, csr_op: op, csr_status: status, ecall: flags[3],
          ebreak: flags[2], mret: flags[1], flush: flags[0], reg_we: we};
    return c;
  endfunction

  function automatic dec_bundle_t mk_bundle(alu_ctrl_t alu, lsu_ctrl_t lsu, md_ctrl_t md,
                                            sys_ctrl_t sys, logic ill);
    dec_bundle_t b;
    b = '{alu: alu, lsu: lsu, md: md, sys: sys, illegal: ill};
    return b;
  endfunction

  `include "decoder_vectors.svh"

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // Monitor and credit model
  ////////////////////
  always @(posedge clk_i) begin
    int idx;
    int acc;
    if (rst_n_i) begin
      cycle++;
      if (instr_ready_o != (outstanding < `DEC_CREDITS)) begin
        $display("Mismatch at time %0t: ready %0b with %0d outstanding", $time,
                 instr_ready_o, outstanding);
        mismatches++;
      end
      if (!instr_ready_o) saw_stall = 1'b1;
      if (bundle_valid_o) begin
        if (idx_q.size() == 0) begin
          $display("Error at time %0t: bundle arrived with no accepted instruction", $time);
          other_errs++;
        end else begin
          idx = idx_q.pop_front();
          acc = acc_cycle_q.pop_front();
          received++;
          if (cycle != acc + 1) begin
            $display("Mismatch at time %0t: row %0d bundle %0d cycles after accept",
                     $time, idx, cycle - acc);
            mismatches++;
          end
          if (bundle_o != exp_tab[idx]) begin
            $display("Mismatch at time %0t: row %0d got %h expected %h", $time, idx,
                     bundle_o, exp_tab[idx]);
            mismatches++;
          end
          due_q.push_back(cycle + delay_tab[idx]);
        end
      end
      if (instr_valid_i && instr_ready_o) begin
        idx_q.push_back(received + idx_q.size());  // Rows go in order
        acc_cycle_q.push_back(cycle);
        outstanding++;
      end
      if (credit_return_i) outstanding--;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        credit_return_i <= 1'b1;
      end else begin
        credit_return_i <= 1'b0;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int waited;
    void'($urandom(32'h8277a707));
    rst_n_i         = 1'b0;
    instr_i         = '0;
    instr_valid_i   = 1'b0;
    credit_return_i = 1'b0;
    load_vectors();
    for (int i = 0; i < NUM_VECS; i++) begin
      delay_tab[i] = int'($urandom_range(3, 0));
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (bundle_valid_o || bundle_o != '0 || !instr_ready_o) begin
      $display("Mismatch at time %0t: wrong state after reset", $time);
      mismatches++;
    end
    for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
      instr_i       <= instr_tab[i];
      instr_valid_i <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!instr_ready_o && waited < WAIT_LIMIT);
      if (!instr_ready_o) begin
        $display("Error: row %0d never accepted, no credit came back", i);
        other_errs++;
        timed_out = 1'b1;
      end
    end
    instr_valid_i <= 1'b0;
    waited = 0;
    while (!timed_out && received < NUM_VECS && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (received != NUM_VECS) begin
      $display("Error: %0d of %0d bundles received, some went missing", received, NUM_VECS);
      other_errs++;
    end
    if (!saw_stall) begin
      $display("Error: ready never dropped with all credits outstanding");
      other_errs++;
    end
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
+incdir+verif
verilog/decoder_pkg.sv
verilog/alu_decoder.sv
verilog/lsu_decoder.sv
verilog/muldiv_decoder.sv
verilog/system_decoder.sv
verilog/decode_ctrl.sv
verilog/decoder_top.sv
verif/decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module decoder_tb -o decoder_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/decoder_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
